/* design/regfile_pkg.sv */
package regfile_pkg;

  // --------------------------------------------------------------------------
  // Register file sizes
  // --------------------------------------------------------------------------

  // Full register address, bank select bit on top
  localparam int ADDR_WIDTH = 6;

  // Width of one register
  localparam int DATA_WIDTH = 32;

  // Bank 0 holds the integer registers
  // Bank 1 holds the floating-point registers
  localparam int NUM_BANKS = 2;

  // Word index inside one bank
  localparam int BANK_ADDR_WIDTH = 5;

  // Registers per bank
  localparam int BANK_WORDS = 32;

  // --------------------------------------------------------------------------
  // Shared data types
  // --------------------------------------------------------------------------

  // Bit 5 picks the bank, bits 4:0 pick the word
  typedef logic [ADDR_WIDTH-1:0] regfile_addr_t;

  // One register value
  typedef logic [DATA_WIDTH-1:0] regfile_data_t;

endpackage

/* design/regfile_write_decoder.sv */
`timescale 1ns/1ps

module regfile_write_decoder (
  // Write port A
  input  regfile_pkg::regfile_addr_t waddr_a_i,
  input  logic                       we_a_i,
  // Write port B
  input  regfile_pkg::regfile_addr_t waddr_b_i,
  input  logic                       we_b_i,
  // One enable bit per register, indexed [bank][word]
  output logic [regfile_pkg::NUM_BANKS-1:0][regfile_pkg::BANK_WORDS-1:0] we_a_dec_o,
  output logic [regfile_pkg::NUM_BANKS-1:0][regfile_pkg::BANK_WORDS-1:0] we_b_dec_o
);

  // --------------------------------------------------------------------------
  // One-hot decode of a single write port
  // --------------------------------------------------------------------------

  function automatic logic [regfile_pkg::NUM_BANKS-1:0][regfile_pkg::BANK_WORDS-1:0]
      decode_port(input regfile_pkg::regfile_addr_t addr, input logic we);
    logic [regfile_pkg::NUM_BANKS-1:0][regfile_pkg::BANK_WORDS-1:0] dec;
    logic [regfile_pkg::ADDR_WIDTH-regfile_pkg::BANK_ADDR_WIDTH-1:0] bank_sel;
    logic [regfile_pkg::BANK_ADDR_WIDTH-1:0] word_sel;
    bank_sel = addr[regfile_pkg::ADDR_WIDTH-1:regfile_pkg::BANK_ADDR_WIDTH];
    word_sel = addr[regfile_pkg::BANK_ADDR_WIDTH-1:0];
    for (int b = 0; b < regfile_pkg::NUM_BANKS; b++) begin
      for (int w = 0; w < regfile_pkg::BANK_WORDS; w++) begin
        // Hit only when both bank and word match
        dec[b][w] = we &&
          (bank_sel == (regfile_pkg::ADDR_WIDTH-regfile_pkg::BANK_ADDR_WIDTH)'(b)) &&
          (word_sel == regfile_pkg::BANK_ADDR_WIDTH'(w));
      end
    end
    // Integer x0 is hardwired to zero, never enable it
    dec[0][0] = 1'b0;
    return dec;
  endfunction

  // --------------------------------------------------------------------------
  // Port enables
  // --------------------------------------------------------------------------

  // Same decode for both ports, priority is resolved in the banks
  always_comb begin
    we_a_dec_o = decode_port(waddr_a_i, we_a_i);
    we_b_dec_o = decode_port(waddr_b_i, we_b_i);
  end

endmodule

/* design/regfile_bank.sv */
`timescale 1ns/1ps

module regfile_bank (
  input  logic                                       clk,
  input  logic                                       rst_n,
  // Per-word write enables for this bank
  input  logic [regfile_pkg::BANK_WORDS-1:0]         we_a_i,
  input  logic [regfile_pkg::BANK_WORDS-1:0]         we_b_i,
  // Write data, shared by every word
  input  regfile_pkg::regfile_data_t                 wdata_a_i,
  input  regfile_pkg::regfile_data_t                 wdata_b_i,
  // Whole bank contents for the read side
  output regfile_pkg::regfile_data_t [regfile_pkg::BANK_WORDS-1:0] bank_mem_o
);

  // Register storage
  regfile_pkg::regfile_data_t [regfile_pkg::BANK_WORDS-1:0] mem_q;

  // --------------------------------------------------------------------------
  // Word registers
  // --------------------------------------------------------------------------

  for (genvar w = 0; w < regfile_pkg::BANK_WORDS; w++) begin : g_word

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        // All registers come up as zero
        mem_q[w] <= '0;
      end else if (we_b_i[w]) begin
        // Port B wins a same-register collision
        mem_q[w] <= wdata_b_i;
      end else if (we_a_i[w]) begin
        mem_q[w] <= wdata_a_i;
      end
    end

  end

  // Reads see the registered value, no bypass of this cycle's write
  assign bank_mem_o = mem_q;

endmodule

/* design/regfile_read_mux.sv */
`timescale 1ns/1ps

module regfile_read_mux (
  // Read addresses
  input  regfile_pkg::regfile_addr_t raddr_a_i,
  input  regfile_pkg::regfile_addr_t raddr_b_i,
  input  regfile_pkg::regfile_addr_t raddr_c_i,
  // Contents of every bank, indexed [bank][word]
  input  regfile_pkg::regfile_data_t
         [regfile_pkg::NUM_BANKS-1:0][regfile_pkg::BANK_WORDS-1:0] bank_mem_i,
  // Read data
  output regfile_pkg::regfile_data_t rdata_a_o,
  output regfile_pkg::regfile_data_t rdata_b_o,
  output regfile_pkg::regfile_data_t rdata_c_o
);

  // --------------------------------------------------------------------------
  // Two-level select for one read port
  // --------------------------------------------------------------------------

  function automatic regfile_pkg::regfile_data_t read_word(
      input regfile_pkg::regfile_addr_t addr,
      input regfile_pkg::regfile_data_t
            [regfile_pkg::NUM_BANKS-1:0][regfile_pkg::BANK_WORDS-1:0] mem);
    regfile_pkg::regfile_data_t [regfile_pkg::NUM_BANKS-1:0] bank_word;
    // First level picks the word inside each bank
    for (int b = 0; b < regfile_pkg::NUM_BANKS; b++) begin
      bank_word[b] = mem[b][addr[regfile_pkg::BANK_ADDR_WIDTH-1:0]];
    end
    // Top address bit then chooses integer or floating point
    return bank_word[addr[regfile_pkg::ADDR_WIDTH-1]];
  endfunction

  // --------------------------------------------------------------------------
  // Read ports
  // --------------------------------------------------------------------------

  // Purely combinational, zero latency
  always_comb begin
    rdata_a_o = read_word(raddr_a_i, bank_mem_i);
    rdata_b_o = read_word(raddr_b_i, bank_mem_i);
    rdata_c_o = read_word(raddr_c_i, bank_mem_i);
  end

endmodule

/* design/regfile_top.sv */
`timescale 1ns/1ps

module regfile_top (
  input  logic                       clk,
  input  logic                       rst_n,

  // Write port A
  input  regfile_pkg::regfile_addr_t waddr_a_i,
  input  regfile_pkg::regfile_data_t wdata_a_i,
  input  logic                       we_a_i,

  // Write port B, higher priority
  input  regfile_pkg::regfile_addr_t waddr_b_i,
  input  regfile_pkg::regfile_data_t wdata_b_i,
  input  logic                       we_b_i,

  // Read ports
  input  regfile_pkg::regfile_addr_t raddr_a_i,
  input  regfile_pkg::regfile_addr_t raddr_b_i,
  input  regfile_pkg::regfile_addr_t raddr_c_i,
  output regfile_pkg::regfile_data_t rdata_a_o,
  output regfile_pkg::regfile_data_t rdata_b_o,
  output regfile_pkg::regfile_data_t rdata_c_o
);

  // Decoded write enables, [bank][word]
  logic [regfile_pkg::NUM_BANKS-1:0][regfile_pkg::BANK_WORDS-1:0] we_a_dec;
  logic [regfile_pkg::NUM_BANKS-1:0][regfile_pkg::BANK_WORDS-1:0] we_b_dec;

  // All register contents, [bank][word]
  regfile_pkg::regfile_data_t
    [regfile_pkg::NUM_BANKS-1:0][regfile_pkg::BANK_WORDS-1:0] bank_mem;

  // --------------------------------------------------------------------------
  // Write address decode
  // --------------------------------------------------------------------------

  regfile_write_decoder regfile_write_decoder_i (
    .waddr_a_i  (waddr_a_i),
    .we_a_i     (we_a_i),
    .waddr_b_i  (waddr_b_i),
    .we_b_i     (we_b_i),
    .we_a_dec_o (we_a_dec),
    .we_b_dec_o (we_b_dec)
  );

  // --------------------------------------------------------------------------
  // Register banks
  // --------------------------------------------------------------------------

  // Bank 0 integer, bank 1 floating point
  for (genvar k = 0; k < regfile_pkg::NUM_BANKS; k++) begin : g_bank
    regfile_bank regfile_bank_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .we_a_i     (we_a_dec[k]),
      .we_b_i     (we_b_dec[k]),
      .wdata_a_i  (wdata_a_i),
      .wdata_b_i  (wdata_b_i),
      .bank_mem_o (bank_mem[k])
    );
  end

  // --------------------------------------------------------------------------
  // Read multiplexer
  // --------------------------------------------------------------------------

  regfile_read_mux regfile_read_mux_i (
    .raddr_a_i  (raddr_a_i),
    .raddr_b_i  (raddr_b_i),
    .raddr_c_i  (raddr_c_i),
    .bank_mem_i (bank_mem),
    .rdata_a_o  (rdata_a_o),
    .rdata_b_o  (rdata_b_o),
    .rdata_c_o  (rdata_c_o)
  );

endmodule

/* verification/regfile_tb.sv */
`timescale 1ns/1ps

module regfile_tb;

  // --------------------------------------------------------------------------
  // Timing and file constants
  // --------------------------------------------------------------------------

  localparam int CLK_PERIOD_NS = 8;
  localparam int RESET_CYCLES  = 16;
  // Margin on top of reset and two cycles per vector
  localparam int SLACK_CYCLES  = 20;
  localparam int SETTLE_NS     = 2;
  localparam string DATA_FILE  = "verification/regfile_testdata.txt";

  // DUT signals
  logic                       clk;
  logic                       rst_n;
  regfile_pkg::regfile_addr_t waddr_a;
  regfile_pkg::regfile_data_t wdata_a;
  logic                       we_a;
  regfile_pkg::regfile_addr_t waddr_b;
  regfile_pkg::regfile_data_t wdata_b;
  logic                       we_b;
  regfile_pkg::regfile_addr_t raddr_a;
  regfile_pkg::regfile_addr_t raddr_b;
  regfile_pkg::regfile_addr_t raddr_c;
  regfile_pkg::regfile_data_t rdata_a;
  regfile_pkg::regfile_data_t rdata_b;
  regfile_pkg::regfile_data_t rdata_c;

  // Vector storage, one entry per data line
  logic                       we_a_q[$];
  regfile_pkg::regfile_addr_t waddr_a_q[$];
  regfile_pkg::regfile_data_t wdata_a_q[$];
  logic                       we_b_q[$];
  regfile_pkg::regfile_addr_t waddr_b_q[$];
  regfile_pkg::regfile_data_t wdata_b_q[$];
  regfile_pkg::regfile_addr_t raddr_a_q[$];
  regfile_pkg::regfile_addr_t raddr_b_q[$];
  regfile_pkg::regfile_addr_t raddr_c_q[$];
  regfile_pkg::regfile_data_t exp_a_q[$];
  regfile_pkg::regfile_data_t exp_b_q[$];
  regfile_pkg::regfile_data_t exp_c_q[$];

  int   num_vectors = 0;
  int   vec_idx     = 0;
  logic load_done   = 1'b0;

  regfile_top regfile_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .waddr_a_i (waddr_a),
    .wdata_a_i (wdata_a),
    .we_a_i    (we_a),
    .waddr_b_i (waddr_b),
    .wdata_b_i (wdata_b),
    .we_b_i    (we_b),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .raddr_c_i (raddr_c),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .rdata_c_o (rdata_c)
  );

  // Free-running clock
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Read data compare for one port
  task automatic check_rdata(input string port,
                             input regfile_pkg::regfile_data_t actual,
                             input regfile_pkg::regfile_data_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t: vector %0d, %s read %h, expected %h",
               $time, vec_idx, port, actual, expected);
      $display("Test failures found");
      $fatal(1, "Read data mismatch");
    end
  endtask

  // Pull every vector out of the data file
  task automatic load_vectors();
    int    fd;
    int    code;
    int    fields;
    int    line_no;
    string line;
    logic  we_a_v;
    logic  we_b_v;
    regfile_pkg::regfile_addr_t wa_a_v;
    regfile_pkg::regfile_addr_t wa_b_v;
    regfile_pkg::regfile_data_t wd_a_v;
    regfile_pkg::regfile_data_t wd_b_v;
    regfile_pkg::regfile_addr_t ra_v;
    regfile_pkg::regfile_addr_t rb_v;
    regfile_pkg::regfile_addr_t rc_v;
    regfile_pkg::regfile_data_t ea_v;
    regfile_pkg::regfile_data_t eb_v;
    regfile_pkg::regfile_data_t ec_v;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the test data file %s", DATA_FILE);
      $display("Test failures found");
      $fatal(1, "Missing test data file");
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      line_no++;
      // Comment lines start with a hash, blank lines are skipped
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                         we_a_v, wa_a_v, wd_a_v, we_b_v, wa_b_v, wd_b_v,
                         ra_v, rb_v, rc_v, ea_v, eb_v, ec_v);
        if (fields != 12) begin
          $display("Line %0d of %s does not hold 12 fields", line_no, DATA_FILE);
          $display("Test failures found");
          $fatal(1, "Malformed test data");
        end
        we_a_q.push_back(we_a_v);
        waddr_a_q.push_back(wa_a_v);
        wdata_a_q.push_back(wd_a_v);
        we_b_q.push_back(we_b_v);
        waddr_b_q.push_back(wa_b_v);
        wdata_b_q.push_back(wd_b_v);
        raddr_a_q.push_back(ra_v);
        raddr_b_q.push_back(rb_v);
        raddr_c_q.push_back(rc_v);
        exp_a_q.push_back(ea_v);
        exp_b_q.push_back(eb_v);
        exp_c_q.push_back(ec_v);
      end
    end
    $fclose(fd);
    num_vectors = we_a_q.size();
  endtask

  // --------------------------------------------------------------------------
  // Stimulus and checking
  // --------------------------------------------------------------------------

  initial begin
    // Idle inputs, reset held
    rst_n   = 1'b0;
    we_a    = 1'b0;
    waddr_a = '0;
    wdata_a = '0;
    we_b    = 1'b0;
    waddr_b = '0;
    wdata_b = '0;
    raddr_a = '0;
    raddr_b = '0;
    raddr_c = '0;
    load_vectors();
    load_done = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < num_vectors; i++) begin
      vec_idx = i;
      // Write ports for this vector, captured at the next rising edge
      @(negedge clk);
      we_a    = we_a_q[i];
      waddr_a = waddr_a_q[i];
      wdata_a = wdata_a_q[i];
      we_b    = we_b_q[i];
      waddr_b = waddr_b_q[i];
      wdata_b = wdata_b_q[i];
      // One edge later, writes off and reads on
      @(negedge clk);
      we_a    = 1'b0;
      we_b    = 1'b0;
      raddr_a = raddr_a_q[i];
      raddr_b = raddr_b_q[i];
      raddr_c = raddr_c_q[i];
      #(SETTLE_NS);
      check_rdata("rdata_a", rdata_a, exp_a_q[i]);
      check_rdata("rdata_b", rdata_b, exp_b_q[i]);
      check_rdata("rdata_c", rdata_c, exp_c_q[i]);
    end
    $display("All tests passed!");
    $finish;
  end

  // Watchdog, sized once the vector count is known
  initial begin
    wait (load_done);
    #((RESET_CYCLES + 2 * num_vectors + SLACK_CYCLES) * CLK_PERIOD_NS);
    $display("Timeout: the run did not finish within the expected time");
    $display("Test failures found");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* verification/regfile_testdata.txt */
# we_a waddr_a wdata_a we_b waddr_b wdata_b raddr_a raddr_b raddr_c exp_a exp_b exp_c
# All fields hex; expected values are the read data one edge after the write
0 05 deadbeef 0 25 cafef00d 00 01 02 00000000 00000000 00000000
0 00 ffffffff 0 20 ffffffff 03 04 05 00000000 00000000 00000000
0 1f 12345678 0 3f 87654321 06 07 08 00000000 00000000 00000000
0 01 a5a5a5a5 0 01 5a5a5a5a 09 0a 0b 00000000 00000000 00000000
0 0c 0000ffff 0 2c ffff0000 0c 0d 0e 00000000 00000000 00000000
0 0f 13579bdf 0 30 2468ace0 0f 10 11 00000000 00000000 00000000
0 12 11111111 0 13 22222222 12 13 14 00000000 00000000 00000000
0 15 33333333 0 35 44444444 15 16 17 00000000 00000000 00000000
0 18 55555555 0 38 66666666 18 19 1a 00000000 00000000 00000000
0 1b 77777777 0 3b 88888888 1b 1c 1d 00000000 00000000 00000000
0 1e 99999999 0 3e aaaaaaaa 1e 1f 20 00000000 00000000 00000000
0 21 bbbbbbbb 0 21 cccccccc 21 22 23 00000000 00000000 00000000
0 24 dddddddd 0 04 eeeeeeee 24 25 26 00000000 00000000 00000000
0 27 01234567 0 07 89abcdef 27 28 29 00000000 00000000 00000000
0 2a fedcba98 0 0a 76543210 2a 2b 2c 00000000 00000000 00000000
0 2d 0f0f0f0f 0 0d f0f0f0f0 2d 2e 2f 00000000 00000000 00000000
0 30 c0ffee00 0 10 00c0ffee 30 31 32 00000000 00000000 00000000
0 33 badc0ffe 0 13 ec0ffee0 33 34 35 00000000 00000000 00000000
0 36 00000001 0 16 80000000 36 37 38 00000000 00000000 00000000
0 39 7fffffff 0 19 fffffffe 39 3a 3b 00000000 00000000 00000000
0 3c 3c3c3c3c 0 1c 1c1c1c1c 3c 3d 3e 00000000 00000000 00000000
0 3f 3f3f3f3f 0 1f 1f1f1f1f 3f 00 20 00000000 00000000 00000000
1 00 11111111 1 20 22222222 00 20 00 00000000 22222222 00000000
1 20 33333333 1 00 44444444 00 20 01 00000000 33333333 00000000
1 05 aaaa0005 1 05 bbbb0005 05 05 05 bbbb0005 bbbb0005 bbbb0005
1 2a a5a5a5a5 1 2a 5a5a5a5a 2a 05 20 5a5a5a5a bbbb0005 33333333
1 07 07070707 1 27 27272727 07 27 00 07070707 27272727 00000000
1 27 f00df00d 1 07 0badc0de 07 27 05 0badc0de f00df00d bbbb0005
1 1f 1f1f1f1f 1 3f 3f3f3f3f 1f 3f 2a 1f1f1f1f 3f3f3f3f 5a5a5a5a
0 05 ffffffff 0 27 eeeeeeee 05 27 1f bbbb0005 f00df00d 1f1f1f1f
1 01 00000001 0 01 12345678 01 01 00 00000001 00000001 00000000
0 01 87654321 1 02 00000002 01 02 3f 00000001 00000002 3f3f3f3f
1 10 10101010 1 30 30303030 10 30 07 10101010 30303030 0badc0de
1 00 ffffffff 1 00 eeeeeeee 00 00 20 00000000 00000000 33333333
1 05 55555555 1 06 66666666 05 06 2a 55555555 66666666 5a5a5a5a
1 3f 00000000 1 1f 12121212 3f 1f 10 00000000 12121212 10101010
0 20 ffffffff 0 20 eeeeeeee 20 3f 1f 33333333 00000000 12121212
1 20 0000abcd 1 21 0000ef01 20 21 06 0000abcd 0000ef01 66666666

/* build.f */
design/regfile_pkg.sv
design/regfile_write_decoder.sv
design/regfile_bank.sv
design/regfile_read_mux.sv
design/regfile_top.sv
verification/regfile_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module regfile_tb -o regfile_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/regfile_sim)
sim_status=$?
printf '%s\n' "$sim_output"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# The run passes only if the testbench printed its pass line
if printf '%s\n' "$sim_output" | grep -qF 'All tests passed!'; then
  exit 0
else
  echo "Pass line not found in simulation output"
  exit 1
fi
